// File: all.f
hw/sys_pkg.sv
hw/clock_gen.sv
hw/work_ram.sv
hw/ppu_regs.sv
hw/bus_merge.sv
hw/nes_system.sv
tests/tb_system.sv

// File: hw/bus_merge.sv
`timescale 1ns/1ps
`default_nettype none

module bus_merge
	import sys_pkg::*;
(
	input  logic        clkCPU2,
	input  logic        n_reset,
	input  bus_req_s    req,
	input  slave_resp_s ram_resp,
	input  slave_resp_s ppu_resp,
	output logic [7:0]  sys_rdata,
	output logic        sys_rdy
);

	logic       xfer_q;
	logic       wr_q;
	logic [7:0] wdata_q;
	logic       src_ram;
	logic       src_ppu;
	logic [7:0] open_bus;

	// Mapped whenever the region decodes to a slave
	assign sys_rdy = req.addr.reg_view.region == REGION_RAM ||
		req.addr.reg_view.region == REGION_PPU;

	// Remember the transfer so the latch follows one cycle later
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset) begin
			xfer_q <= 1'b0;
			wr_q <= 1'b0;
			src_ram <= 1'b0;
			src_ppu <= 1'b0;
		end else begin
			xfer_q <= req.ce;
			if (req.ce) begin
				wr_q <= !req.rw;
				// Source only changes on reads, so read data holds
				if (req.rw) begin
					src_ram <= ram_resp.sel;
					src_ppu <= ppu_resp.sel;
				end
			end
		end
	end

	always_ff @(posedge clkCPU2) begin
		if (req.ce)
			wdata_q <= req.wdata;
	end

	always_comb begin
		if (src_ram)
			sys_rdata = ram_resp.rdata;
		else if (src_ppu)
			sys_rdata = ppu_resp.rdata;
		else
			sys_rdata = open_bus;
	end

	// Last value seen on the bus, for unmapped reads
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset)
			open_bus <= 8'h00;
		else if (xfer_q)
			open_bus <= wr_q ? wdata_q : sys_rdata;
	end

endmodule

`default_nettype wire

// File: hw/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	input  logic clkCPU2,
	input  logic n_reset,
	output logic clk_cpu,
	output logic clk_cpu_n,
	output logic clk_ram,
	output logic cpu_ce
);

	// CPU phase at half the input rate, plus its one-cycle delayed copy
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset) begin
			clk_cpu <= 1'b1;
			clk_cpu_n <= 1'b1;
		end else begin
			clk_cpu <= ~clk_cpu;
			clk_cpu_n <= clk_cpu;
		end
	end

	// RAM clock picks up the phase half a cycle later
	always_ff @(negedge clkCPU2, negedge n_reset) begin
		if (!n_reset)
			clk_ram <= 1'b1;
		else
			clk_ram <= clk_cpu;
	end

	// High in the cycles where clk_cpu is high, quiet through reset
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset)
			cpu_ce <= 1'b0;
		else
			cpu_ce <= ~clk_cpu;
	end

endmodule

`default_nettype wire

// File: hw/nes_system.sv
`timescale 1ns/1ps
`default_nettype none

module nes_system
	import sys_pkg::*;
#(
	parameter int FRAME_CYCLES  = 64,
	parameter int VBLANK_CYCLES = 16
) (
	input  logic        clkCPU2,
	input  logic        n_reset,
	output logic        clkCPU,
	output logic        clkCPUn,
	output logic        clkRAM,
	input  logic [15:0] sys_addr,
	input  logic [7:0]  sys_wdata,
	input  logic        sys_rw,
	output logic [7:0]  sys_rdata,
	output logic        sys_rdy,
	output logic        nmi
);

	logic        cpu_ce;
	bus_req_s    bus_req;
	slave_resp_s ram_resp;
	slave_resp_s ppu_resp;

	clock_gen u_clock_gen (
		.clkCPU2  (clkCPU2),
		.n_reset  (n_reset),
		.clk_cpu  (clkCPU),
		.clk_cpu_n(clkCPUn),
		.clk_ram  (clkRAM),
		.cpu_ce   (cpu_ce)
	);

	// One request word shared by every slave
	assign bus_req.addr = bus_addr_u'(sys_addr);
	assign bus_req.wdata = sys_wdata;
	assign bus_req.rw = sys_rw;
	assign bus_req.ce = cpu_ce;

	work_ram u_work_ram (
		.clkCPU2(clkCPU2),
		.n_reset(n_reset),
		.req    (bus_req),
		.resp   (ram_resp)
	);

	ppu_regs #(
		.FRAME_CYCLES (FRAME_CYCLES),
		.VBLANK_CYCLES(VBLANK_CYCLES)
	) u_ppu_regs (
		.clkCPU2(clkCPU2),
		.n_reset(n_reset),
		.req    (bus_req),
		.resp   (ppu_resp),
		.nmi    (nmi)
	);

	bus_merge u_bus_merge (
		.clkCPU2  (clkCPU2),
		.n_reset  (n_reset),
		.req      (bus_req),
		.ram_resp (ram_resp),
		.ppu_resp (ppu_resp),
		.sys_rdata(sys_rdata),
		.sys_rdy  (sys_rdy)
	);

endmodule

`default_nettype wire

// File: hw/ppu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_regs
	import sys_pkg::*;
#(
	parameter int FRAME_CYCLES  = 64,
	parameter int VBLANK_CYCLES = 16
) (
	input  logic        clkCPU2,
	input  logic        n_reset,
	input  bus_req_s    req,
	output slave_resp_s resp,
	output logic        nmi
);

	localparam int TW = $clog2(FRAME_CYCLES);

	logic [TW-1:0] timer;
	logic          vblank;
	logic          nmi_en;
	logic [7:0]    oam_addr;
	logic [7:0]    oam [256];
	logic [7:0]    rdata_q;
	logic          sel;
	logic [2:0]    index;
	logic          rd;
	logic          wr;

	assign sel = req.addr.reg_view.region == REGION_PPU;
	assign index = req.addr.reg_view.index;
	assign rd = req.ce && sel && req.rw;
	assign wr = req.ce && sel && !req.rw;

	// Frame timer and vblank window
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset) begin
			timer <= '0;
			vblank <= 1'b0;
		end else if (req.ce) begin
			if (timer == TW'(FRAME_CYCLES - 1))
				timer <= '0;
			else
				timer <= timer + 1'b1;

			if (rd && index == PPU_REG_STATUS)
				vblank <= 1'b0;
			if (timer == TW'(VBLANK_CYCLES - 1))
				vblank <= 1'b0;
			// Start of a new frame wins over a status read in the same cycle
			if (timer == TW'(FRAME_CYCLES - 1))
				vblank <= 1'b1;
		end
	end

	// Control register, only the NMI enable bit is kept
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset)
			nmi_en <= 1'b0;
		else if (wr && index == PPU_REG_CTRL)
			nmi_en <= req.wdata[7];
	end

	// OAM address, auto-increment on data writes only
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset)
			oam_addr <= 8'h00;
		else if (wr && index == PPU_REG_OAMADDR)
			oam_addr <= req.wdata;
		else if (wr && index == PPU_REG_OAMDATA)
			oam_addr <= oam_addr + 8'd1;
	end

	always_ff @(posedge clkCPU2) begin
		if (wr && index == PPU_REG_OAMDATA)
			oam[oam_addr] <= req.wdata;
	end

	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset) begin
			rdata_q <= 8'h00;
		end else if (rd) begin
			case (index)
				PPU_REG_STATUS:  rdata_q <= {vblank, 7'b0};
				PPU_REG_OAMDATA: rdata_q <= oam[oam_addr];
				default:         rdata_q <= 8'h00;
			endcase
		end
	end

	assign resp.sel = sel;
	assign resp.rdata = rdata_q;
	assign nmi = vblank & nmi_en;

endmodule

`default_nettype wire

// File: hw/sys_pkg.sv
`default_nettype none

package sys_pkg;

	// Low 2 kB offset, upper bits only mirror the RAM
	typedef struct packed {
		logic [4:0]  mirror;
		logic [10:0] offset;
	} ram_view_s;

	// Register block view, 8-byte window repeated through the region
	typedef struct packed {
		logic [2:0] region;
		logic [9:0] mirror;
		logic [2:0] index;
	} reg_view_s;

	// Same CPU address seen by both slaves
	typedef union packed {
		ram_view_s ram_view;
		reg_view_s reg_view;
	} bus_addr_u;

	// Top three address bits, anything else is unmapped
	typedef enum logic [2:0] {
		REGION_RAM = 3'b000,
		REGION_PPU = 3'b001
	} region_e;

	typedef struct packed {
		bus_addr_u  addr;
		logic [7:0] wdata;
		logic       rw;
		logic       ce;
	} bus_req_s;

	typedef struct packed {
		logic       sel;
		logic [7:0] rdata;
	} slave_resp_s;

	// Picture unit register indices
	localparam logic [2:0] PPU_REG_CTRL    = 3'd0;
	localparam logic [2:0] PPU_REG_STATUS  = 3'd2;
	localparam logic [2:0] PPU_REG_OAMADDR = 3'd3;
	localparam logic [2:0] PPU_REG_OAMDATA = 3'd4;

endpackage

`default_nettype wire

// File: hw/work_ram.sv
`timescale 1ns/1ps
`default_nettype none

module work_ram
	import sys_pkg::*;
(
	input  logic        clkCPU2,
	input  logic        n_reset,
	input  bus_req_s    req,
	output slave_resp_s resp
);

	logic [7:0]  mem [2048];
	logic [7:0]  rdata_q;
	logic        sel;
	logic [10:0] offset;

	// Only the offset indexes the array, so the 2 kB repeats four times
	assign offset = req.addr.ram_view.offset;

	// Upper three address bits give the region
	assign sel = req.addr.ram_view.mirror[4:2] == REGION_RAM;

	always_ff @(posedge clkCPU2) begin
		if (req.ce && sel && !req.rw)
			mem[offset] <= req.wdata;
	end

	// Read data stays until the next read of this RAM
	always_ff @(posedge clkCPU2, negedge n_reset) begin
		if (!n_reset)
			rdata_q <= 8'h00;
		else if (req.ce && sel && req.rw)
			rdata_q <= mem[offset];
	end

	assign resp.sel = sel;
	assign resp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_system -f all.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tests/tb_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_system
	import sys_pkg::*;
();

	localparam int          RAM_WRITES     = 16;
	localparam int          OAM_BYTES      = 8;
	localparam logic [15:0] PARK_ADDR      = 16'hFFFF;
	localparam logic [31:0] RANDOM_SEED    = 32'hb1c9_c11c;
	// About 600 cycles of bus traffic, three frames of 128 cycles, and wide margin
	localparam int          TIMEOUT_CYCLES = 4000;

	logic        clkCPU2;
	logic        n_reset;
	logic        clkCPU;
	logic        clkCPUn;
	logic        clkRAM;
	logic [15:0] sys_addr;
	logic [7:0]  sys_wdata;
	logic        sys_rw;
	logic [7:0]  sys_rdata;
	logic        sys_rdy;
	logic        nmi;

	logic [7:0]  ram_model [2048];
	logic [7:0]  oam_model [256];
	logic [10:0] offsets [RAM_WRITES];
	logic [7:0]  rdata;
	logic        rdy;
	logic        prev_cpu;
	logic [7:0]  oam_start;
	logic [7:0]  oam_idx;
	logic [7:0]  value;
	int          cycle_count;

	nes_system #(
		.FRAME_CYCLES (64),
		.VBLANK_CYCLES(16)
	) UUT (
		.clkCPU2  (clkCPU2),
		.n_reset  (n_reset),
		.clkCPU   (clkCPU),
		.clkCPUn  (clkCPUn),
		.clkRAM   (clkRAM),
		.sys_addr (sys_addr),
		.sys_wdata(sys_wdata),
		.sys_rw   (sys_rw),
		.sys_rdata(sys_rdata),
		.sys_rdy  (sys_rdy),
		.nmi      (nmi)
	);

	always #10 clkCPU2 = ~clkCPU2;

	always @(posedge clkCPU2) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic expect_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s: expected %02h, actual %02h", name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "Check %s stopped the run", name);
		end
	endtask

	// One CPU cycle, request held from the low phase through the data sample
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] wdata,
		input logic rw, output logic [7:0] data, output logic ready);
		while (!(clkCPU2 === 1'b0 && clkCPU === 1'b0))
			@(negedge clkCPU2);
		sys_addr = addr;
		sys_wdata = wdata;
		sys_rw = rw;
		@(negedge clkCPU2);
		@(negedge clkCPU2);
		data = sys_rdata;
		ready = sys_rdy;
		// Unmapped read leaves the slaves and the latch unchanged
		sys_addr = PARK_ADDR;
		sys_rw = 1'b1;
	endtask

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] unused_data;
		logic       unused_ready;
		bus_cycle(addr, data, 1'b0, unused_data, unused_ready);
	endtask

	task automatic read_byte(input logic [15:0] addr, output logic [7:0] data,
		output logic ready);
		bus_cycle(addr, 8'h00, 1'b1, data, ready);
	endtask

	function automatic logic [15:0] pick_reg_addr(input logic [2:0] index);
		return 16'h2000 | (16'($urandom) & 16'h1FF8) | {13'd0, index};
	endfunction

	function automatic logic [15:0] pick_unmapped_addr();
		return 16'h4000 + 16'($urandom % 32'h0000_C000);
	endfunction

	initial begin
		clkCPU2 = 1'b0;
		n_reset = 1'b0;
		sys_addr = PARK_ADDR;
		sys_wdata = 8'h00;
		sys_rw = 1'b1;
		cycle_count = 0;
		void'($urandom(RANDOM_SEED));

		repeat (8) @(negedge clkCPU2);
		expect_byte("reset_clk_cpu", 8'h01, {7'd0, clkCPU});
		expect_byte("reset_clk_cpu_n", 8'h01, {7'd0, clkCPUn});
		expect_byte("reset_clk_ram", 8'h01, {7'd0, clkRAM});
		n_reset = 1'b1;

		// Phase toggles at rising edges, RAM clock follows at falling edges
		prev_cpu = 1'b1;
		repeat (8) begin
			@(negedge clkCPU2);
			expect_byte("clk_cpu_toggle", {7'd0, ~prev_cpu}, {7'd0, clkCPU});
			expect_byte("clk_cpu_n_delay", {7'd0, prev_cpu}, {7'd0, clkCPUn});
			prev_cpu = ~prev_cpu;
			@(posedge clkCPU2);
			expect_byte("clk_ram_phase", {7'd0, prev_cpu}, {7'd0, clkRAM});
		end

		for (int i = 0; i < RAM_WRITES; i++) begin
			offsets[i] = 11'($urandom);
			value = 8'($urandom);
			ram_model[offsets[i]] = value;
			write_byte({5'd0, offsets[i]}, value);
		end
		for (int i = 0; i < RAM_WRITES; i++) begin
			for (int m = 1; m < 4; m++) begin
				read_byte({3'b000, 2'(m), offsets[i]}, rdata, rdy);
				expect_byte("ram_mirror", ram_model[offsets[i]], rdata);
				expect_byte("ram_rdy", 8'h01, {7'd0, rdy});
			end
		end

		// Sprite memory through a high mirror of the register window
		oam_start = 8'($urandom);
		write_byte(16'h3FF3, oam_start);
		for (int i = 0; i < OAM_BYTES; i++) begin
			oam_idx = oam_start + 8'(i);
			oam_model[oam_idx] = 8'($urandom);
			write_byte(16'h3FF4, oam_model[oam_idx]);
		end
		for (int i = 0; i < OAM_BYTES; i++) begin
			oam_idx = oam_start + 8'(i);
			write_byte(pick_reg_addr(PPU_REG_OAMADDR), oam_idx);
			read_byte(pick_reg_addr(PPU_REG_OAMDATA), rdata, rdy);
			expect_byte("oam_readback", oam_model[oam_idx], rdata);
			expect_byte("ppu_rdy", 8'h01, {7'd0, rdy});
		end

		// Vblank seen by polling while NMI is masked
		write_byte(pick_reg_addr(PPU_REG_CTRL), 8'h00);
		rdata = 8'h00;
		while (rdata[7] !== 1'b1) begin
			read_byte(pick_reg_addr(PPU_REG_STATUS), rdata, rdy);
			expect_byte("nmi_masked", 8'h00, {7'd0, nmi});
		end
		write_byte(pick_reg_addr(PPU_REG_CTRL), 8'h80);
		expect_byte("nmi_after_enable", 8'h00, {7'd0, nmi});
		while (nmi !== 1'b1)
			@(negedge clkCPU2);
		read_byte(pick_reg_addr(PPU_REG_STATUS), rdata, rdy);
		expect_byte("status_vblank", 8'h80, rdata);
		expect_byte("nmi_cleared", 8'h00, {7'd0, nmi});
		read_byte(pick_reg_addr(PPU_REG_STATUS), rdata, rdy);
		expect_byte("status_repeat", 8'h00, rdata);

		for (int i = 0; i < 4; i++) begin
			value = 8'($urandom);
			ram_model[offsets[i]] = value;
			write_byte({3'b000, 2'($urandom), offsets[i]}, value);
			read_byte(pick_unmapped_addr(), rdata, rdy);
			expect_byte("open_bus_write", value, rdata);
			expect_byte("open_bus_rdy", 8'h00, {7'd0, rdy});
			read_byte({5'd0, offsets[i + 4]}, rdata, rdy);
			expect_byte("ram_known", ram_model[offsets[i + 4]], rdata);
			read_byte(pick_unmapped_addr(), rdata, rdy);
			expect_byte("open_bus_read", ram_model[offsets[i + 4]], rdata);
			expect_byte("open_bus_rdy", 8'h00, {7'd0, rdy});
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
